// File: duck_hunt_pkg.sv
// ----------------------------
// duck hunt shared definitions: screen geometry,
// pixel types, colours, sprite shapes, sequencer states
// ----------------------------
package duck_hunt_pkg;

	typedef logic [7:0] pix_x_t;
	typedef logic [6:0] pix_y_t;
	typedef logic [2:0] colour_t; // {r, g, b}
	typedef logic signed [3:0] offset_t;
	typedef logic [3:0] shape_idx_t;

	typedef struct packed {
		offset_t dx;
		offset_t dy;
	} shape_off_t;

	localparam colour_t COLOUR_BG = 3'b000;
	localparam colour_t COLOUR_BIRD = 3'b111;
	localparam colour_t COLOUR_HUNTER = 3'b001; // blue only

	localparam int SCREEN_W = 160;
	localparam int SCREEN_H = 120;

	localparam int NUM_BIRDS = 6;
	localparam int BIRD_SPACING = 26;
	localparam int BIRD_PIXELS = 13;

	// head column and base row are the origin, the body trails to the left
	localparam shape_off_t BIRD_SHAPE [BIRD_PIXELS] = '{
		'{4'sd0, 4'sd0},
		'{4'sd0, 4'sd1},
		'{-4'sd1, 4'sd0},
		'{-4'sd2, 4'sd0},
		'{-4'sd3, 4'sd0},
		'{-4'sd4, 4'sd0},
		'{-4'sd5, 4'sd0},
		'{-4'sd3, 4'sd1}, // wings
		'{-4'sd3, -4'sd1},
		'{-4'sd4, 4'sd2},
		'{-4'sd4, -4'sd2},
		'{-4'sd5, 4'sd3},
		'{-4'sd5, -4'sd3}
	};

	localparam int HUNTER_PIXELS = 10;
	localparam int HUNTER_ROW = 116;
	localparam int HUNTER_W = 4;
	localparam int HUNTER_START_X = 78;

	localparam shape_off_t HUNTER_SHAPE [HUNTER_PIXELS] = '{
		'{4'sd1, 4'sd0}, // head
		'{4'sd2, 4'sd0},
		'{4'sd0, 4'sd1},
		'{4'sd1, 4'sd1},
		'{4'sd2, 4'sd1},
		'{4'sd3, 4'sd1},
		'{4'sd0, 4'sd2},
		'{4'sd1, 4'sd2},
		'{4'sd2, 4'sd2},
		'{4'sd3, 4'sd2}
	};

	typedef enum logic [1:0] {
		IDLE,
		START,
		STREAM,
		NEXT
	} seq_state_t;

endpackage

// File: sprite_if.sv
`timescale 1ns/100ps
// ----------------------------
// start/pixel handshake between the sequencer and one sprite
// ----------------------------
interface sprite_if;
	import duck_hunt_pkg::*;

	logic start; // one-cycle pass request
	logic erase; // sampled with start
	logic valid;
	pix_x_t x;
	pix_y_t y;
	logic last;
	logic ready;

	modport seq (
		output start,
		output erase,
		output ready,
		input valid,
		input x,
		input y,
		input last
	);

	modport sprite (
		input start,
		input erase,
		input ready,
		output valid,
		output x,
		output y,
		output last
	);

endinterface

// File: frame_timer.sv
`timescale 1ns/100ps
// ----------------------------
// frame timer: clock to frame ticks to game steps
// ----------------------------
module frame_timer #(
	parameter int TICKS_PER_FRAME = 833333,
	parameter int FRAMES_PER_STEP = 15
) (
	input logic clock,
	input logic reset,
	output logic step
);

	localparam int TICK_W = $clog2(TICKS_PER_FRAME + 1);
	localparam int FRAME_W = $clog2(FRAMES_PER_STEP + 1);

	logic [TICK_W-1:0] tick_cnt;
	logic [FRAME_W-1:0] frame_cnt;
	logic tick_zero;
	logic frame_zero;

	assign tick_zero = (tick_cnt == '0);
	assign frame_zero = (frame_cnt == '0);

	always_ff @(posedge clock or negedge reset)
	begin
		if (!reset)
		begin
			tick_cnt <= TICK_W'(TICKS_PER_FRAME - 1);
			frame_cnt <= FRAME_W'(FRAMES_PER_STEP - 1);
			step <= 1'b0;
		end
		else
		begin
			step <= tick_zero && frame_zero;
			if (tick_zero)
			begin
				tick_cnt <= TICK_W'(TICKS_PER_FRAME - 1); // end of frame
				if (frame_zero)
					frame_cnt <= FRAME_W'(FRAMES_PER_STEP - 1);
				else
					frame_cnt <= frame_cnt - 1'b1;
			end
			else
				tick_cnt <= tick_cnt - 1'b1;
		end
	end

endmodule

// File: bird_sprite.sv
`timescale 1ns/100ps
// ----------------------------
// bird sprite: flies right one column per step,
// new LFSR row on each wrap, replays its shape on request
// ----------------------------
module bird_sprite #(
	parameter int START_X = 0,
	parameter int LFSR_SEED = 1
) (
	input logic clock,
	input logic reset,
	input logic step,
	sprite_if.sprite pix
);
	import duck_hunt_pkg::*;

	localparam pix_y_t START_ROW = pix_y_t'(LFSR_SEED * 8 + 4);

	pix_x_t column;
	logic [2:0] lfsr;
	logic [2:0] lfsr_next;
	logic n2;
	logic n1;
	pix_y_t row;
	pix_x_t shown_x;
	pix_y_t shown_y;
	shape_idx_t idx;
	logic active;
	shape_off_t off;

	// each new bit folds in the one just computed
	always_comb
	begin
		n2 = lfsr[2] ^ lfsr[0];
		n1 = lfsr[1] ^ n2;
		lfsr_next = {n2, n1, lfsr[0] ^ n1};
	end

	assign row = pix_y_t'({lfsr, 3'b100}); // lfsr * 8 + 4

	always_ff @(posedge clock or negedge reset)
	begin
		if (!reset)
		begin
			column <= pix_x_t'(START_X);
			lfsr <= 3'(LFSR_SEED);
		end
		else if (step)
		begin
			if (column == pix_x_t'(SCREEN_W - 1))
			begin
				column <= '0; // wrap, pick a new row
				lfsr <= lfsr_next;
			end
			else
				column <= column + 1'b1;
		end
	end

	always_ff @(posedge clock or negedge reset)
	begin
		if (!reset)
		begin
			active <= 1'b0;
			idx <= '0;
			shown_x <= pix_x_t'(START_X);
			shown_y <= START_ROW;
		end
		else if (pix.start)
		begin
			active <= 1'b1;
			idx <= '0;
			if (!pix.erase)
			begin
				shown_x <= column; // draw latches current position
				shown_y <= row;
			end
		end
		else if (active && pix.ready)
		begin
			if (pix.last)
				active <= 1'b0;
			else
				idx <= idx + 1'b1;
		end
	end

	assign off = BIRD_SHAPE[idx];
	assign pix.valid = active;
	assign pix.last = (idx == shape_idx_t'(BIRD_PIXELS - 1));
	assign pix.x = shown_x + pix_x_t'(off.dx);
	assign pix.y = shown_y + pix_y_t'(off.dy);

endmodule

// File: hunter_sprite.sv
`timescale 1ns/100ps
// ----------------------------
// hunter sprite: button movement clamped to the screen,
// shape replay at the bottom row
// ----------------------------
module hunter_sprite (
	input logic clock,
	input logic reset,
	input logic step,
	input logic move_left,
	input logic move_right,
	sprite_if.sprite pix
);
	import duck_hunt_pkg::*;

	pix_x_t column;
	pix_x_t shown_x;
	shape_idx_t idx;
	logic active;
	shape_off_t off;

	always_ff @(posedge clock or negedge reset)
	begin
		if (!reset)
			column <= pix_x_t'(HUNTER_START_X);
		else if (step)
		begin
			// right wins when both are held
			if (move_right && column < pix_x_t'(SCREEN_W - HUNTER_W))
				column <= column + 1'b1;
			else if (move_left && column != '0)
				column <= column - 1'b1;
		end
	end

	always_ff @(posedge clock or negedge reset)
	begin
		if (!reset)
		begin
			active <= 1'b0;
			idx <= '0;
			shown_x <= pix_x_t'(HUNTER_START_X);
		end
		else if (pix.start)
		begin
			active <= 1'b1;
			idx <= '0;
			if (!pix.erase)
				shown_x <= column;
		end
		else if (active && pix.ready)
		begin
			if (pix.last)
				active <= 1'b0;
			else
				idx <= idx + 1'b1;
		end
	end

	assign off = HUNTER_SHAPE[idx];
	assign pix.valid = active;
	assign pix.last = (idx == shape_idx_t'(HUNTER_PIXELS - 1));
	assign pix.x = shown_x + pix_x_t'(off.dx);
	assign pix.y = pix_y_t'(HUNTER_ROW) + pix_y_t'(off.dy); // row is fixed

endmodule

// File: render_sequencer.sv
`timescale 1ns/100ps
// ----------------------------
// render sequencer: erase/draw pass per sprite on each step,
// muxes the sprites onto the pixel stream
// ----------------------------
module render_sequencer (
	input logic clock,
	input logic reset,
	input logic step,
	sprite_if.seq birds [duck_hunt_pkg::NUM_BIRDS],
	sprite_if.seq hunter,
	input logic pixel_ready,
	output logic pixel_valid,
	output duck_hunt_pkg::pix_x_t pixel_x,
	output duck_hunt_pkg::pix_y_t pixel_y,
	output duck_hunt_pkg::colour_t pixel_colour
);
	import duck_hunt_pkg::*;

	localparam int IDX_W = $clog2(NUM_BIRDS + 1);
	localparam logic [IDX_W-1:0] HUNTER_IDX = IDX_W'(NUM_BIRDS); // after the birds

	seq_state_t state;
	logic [IDX_W-1:0] idx;
	logic erase;
	logic pending;
	logic start_pulse;
	logic hunter_sel;
	logic accept_last;
	logic sel_valid;
	logic sel_last;
	pix_x_t sel_x;
	pix_y_t sel_y;
	logic [NUM_BIRDS-1:0] bird_valid;
	logic [NUM_BIRDS-1:0] bird_last;
	pix_x_t bird_x [NUM_BIRDS];
	pix_y_t bird_y [NUM_BIRDS];

	assign start_pulse = (state == START) || (state == NEXT);
	assign hunter_sel = (idx == HUNTER_IDX);

	genvar i;
	generate
		for (i = 0; i < NUM_BIRDS; i++)
		begin : g_bird_port
			assign birds[i].start = start_pulse && (idx == IDX_W'(i));
			assign birds[i].erase = erase;
			assign birds[i].ready = pixel_ready && (idx == IDX_W'(i));
			assign bird_valid[i] = birds[i].valid;
			assign bird_last[i] = birds[i].last;
			assign bird_x[i] = birds[i].x;
			assign bird_y[i] = birds[i].y;
		end
	endgenerate

	assign hunter.start = start_pulse && hunter_sel;
	assign hunter.erase = erase;
	assign hunter.ready = pixel_ready && hunter_sel;

	always_comb
	begin
		if (hunter_sel)
		begin
			sel_valid = hunter.valid;
			sel_last = hunter.last;
			sel_x = hunter.x;
			sel_y = hunter.y;
		end
		else
		begin
			sel_valid = bird_valid[idx];
			sel_last = bird_last[idx];
			sel_x = bird_x[idx];
			sel_y = bird_y[idx];
		end
	end

	assign accept_last = sel_valid && pixel_ready && sel_last;

	assign pixel_valid = sel_valid;
	assign pixel_x = sel_x;
	assign pixel_y = sel_y;
	assign pixel_colour = erase ? COLOUR_BG : (hunter_sel ? COLOUR_HUNTER : COLOUR_BIRD);

	always_ff @(posedge clock or negedge reset)
	begin
		if (!reset)
		begin
			state <= IDLE;
			idx <= '0;
			erase <= 1'b1;
			pending <= 1'b0;
		end
		else
		begin
			if (step && state != IDLE)
				pending <= 1'b1; // busy, keep one step for later
			case (state)
				IDLE:
					if (step || pending)
					begin
						state <= START;
						idx <= '0;
						erase <= 1'b1;
						pending <= 1'b0;
					end
				START, NEXT:
					state <= STREAM;
				STREAM:
					if (accept_last)
					begin
						if (erase)
						begin
							erase <= 1'b0; // same sprite, draw pass
							state <= NEXT;
						end
						else if (hunter_sel)
							state <= IDLE; // scene done
						else
						begin
							idx <= idx + 1'b1;
							erase <= 1'b1;
							state <= NEXT;
						end
					end
				default:
					state <= IDLE;
			endcase
		end
	end

endmodule

// File: duck_hunt_top.sv
`timescale 1ns/100ps
// ----------------------------
// duck hunt core: timer, six birds, hunter and renderer
// ending in a pixel write stream
// ----------------------------
module duck_hunt_top #(
	parameter int TICKS_PER_FRAME = 833333,
	parameter int FRAMES_PER_STEP = 15
) (
	input logic clock,
	input logic reset,
	input logic move_left,
	input logic move_right,
	input logic pixel_ready,
	output logic pixel_valid,
	output duck_hunt_pkg::pix_x_t pixel_x,
	output duck_hunt_pkg::pix_y_t pixel_y,
	output duck_hunt_pkg::colour_t pixel_colour
);
	import duck_hunt_pkg::*;

	logic step;

	sprite_if bird_pix [NUM_BIRDS] ();
	sprite_if hunter_pix ();

	frame_timer #(
		.TICKS_PER_FRAME(TICKS_PER_FRAME),
		.FRAMES_PER_STEP(FRAMES_PER_STEP)
	) u_frame_timer (
		.clock(clock),
		.reset(reset),
		.step(step)
	);

	genvar i;
	generate
		for (i = 0; i < NUM_BIRDS; i++)
		begin : g_bird
			// birds start evenly spread, each with its own seed
			bird_sprite #(
				.START_X(i * BIRD_SPACING),
				.LFSR_SEED(i + 1)
			) u_bird (
				.clock(clock),
				.reset(reset),
				.step(step),
				.pix(bird_pix[i])
			);
		end
	endgenerate

	hunter_sprite u_hunter (
		.clock(clock),
		.reset(reset),
		.step(step),
		.move_left(move_left),
		.move_right(move_right),
		.pix(hunter_pix)
	);

	render_sequencer u_sequencer (
		.clock(clock),
		.reset(reset),
		.step(step),
		.birds(bird_pix),
		.hunter(hunter_pix),
		.pixel_ready(pixel_ready),
		.pixel_valid(pixel_valid),
		.pixel_x(pixel_x),
		.pixel_y(pixel_y),
		.pixel_colour(pixel_colour)
	);

endmodule

// File: duck_hunt_chk.sv
`timescale 1ns/100ps
// ------------------------------
// pixel stream handshake and reset checks
// ------------------------------
module duck_hunt_chk (
	input logic clock,
	input logic reset,
	input logic pixel_valid,
	input logic pixel_ready,
	input duck_hunt_pkg::pix_x_t pixel_x,
	input duck_hunt_pkg::pix_y_t pixel_y,
	input duck_hunt_pkg::colour_t pixel_colour
);
	import duck_hunt_pkg::*;

	int fail_count = 0;

	no_valid_in_reset: assert property (@(posedge clock) !reset |-> !pixel_valid)
	else
	begin
		$error("pixel_valid high while reset is active");
		fail_count++;
	end

	// stalled pixel must wait unchanged
	hold_while_stalled: assert property (@(posedge clock) disable iff (!reset)
		pixel_valid && !pixel_ready |=> pixel_valid && $stable(pixel_x)
			&& $stable(pixel_y) && $stable(pixel_colour))
	else
	begin
		$error("pixel changed or dropped while stalled");
		fail_count++;
	end

	known_colour: assert property (@(posedge clock) disable iff (!reset)
		pixel_valid |-> (pixel_colour == COLOUR_BG || pixel_colour == COLOUR_BIRD
			|| pixel_colour == COLOUR_HUNTER))
	else
	begin
		$error("pixel_colour %0d is not a scene colour", pixel_colour);
		fail_count++;
	end

endmodule

bind duck_hunt_top duck_hunt_chk u_chk (
	.clock(clock),
	.reset(reset),
	.pixel_valid(pixel_valid),
	.pixel_ready(pixel_ready),
	.pixel_x(pixel_x),
	.pixel_y(pixel_y),
	.pixel_colour(pixel_colour)
);

// File: tb_duck_hunt.sv
`timescale 1ns/100ps
// ------------------------------
// duck hunt testbench comparing the pixel stream
// with a reference model of the scene
// ------------------------------
module tb_duck_hunt;
	import duck_hunt_pkg::*;

	localparam int STEP_CYCLES = 300 * 2;
	localparam int PASS_PIXELS = 176;
	localparam int PLANNED_STEPS = 1 + 10 + 90 + 170 + 170;
	localparam int CYCLE_LIMIT = PLANNED_STEPS * STEP_CYCLES * 2;
	localparam int HUNTER_DRAW_FIRST = NUM_BIRDS * 26 + 10; // after the hunter erase

	// shape offsets of the game sprites
	localparam int BIRD_DX [13] = '{0, 0, -1, -2, -3, -4, -5, -3, -3, -4, -4, -5, -5};
	localparam int BIRD_DY [13] = '{0, 1, 0, 0, 0, 0, 0, 1, -1, 2, -2, 3, -3};
	localparam int HUNTER_DX [10] = '{1, 2, 0, 1, 2, 3, 0, 1, 2, 3};
	localparam int HUNTER_DY [10] = '{0, 0, 1, 1, 1, 1, 2, 2, 2, 2};

	logic clock;
	logic reset;
	logic move_left;
	logic move_right;
	logic pixel_ready;
	logic pixel_valid;
	pix_x_t pixel_x;
	pix_y_t pixel_y;
	colour_t pixel_colour;

	int bird_col [NUM_BIRDS];
	logic [2:0] bird_lfsr [NUM_BIRDS];
	int bird_sx [NUM_BIRDS];
	int bird_sy [NUM_BIRDS];
	int bird_wraps [NUM_BIRDS]; // draw passes seen at column 0
	int hunter_col;
	int hunter_sx;
	logic [17:0] exp_pix [PASS_PIXELS];
	int hunter_seen_x;
	int errors;
	int checks;
	int cycle_count;

	duck_hunt_top #(
		.TICKS_PER_FRAME(300),
		.FRAMES_PER_STEP(2)
	) UUT (
		.clock(clock),
		.reset(reset),
		.move_left(move_left),
		.move_right(move_right),
		.pixel_ready(pixel_ready),
		.pixel_valid(pixel_valid),
		.pixel_x(pixel_x),
		.pixel_y(pixel_y),
		.pixel_colour(pixel_colour)
	);

	function automatic logic [2:0] lfsr_advance(input logic [2:0] s);
		logic n2;
		logic n1;
		logic n0;
		n2 = s[2] ^ s[0];
		n1 = s[1] ^ n2;
		n0 = s[0] ^ n1;
		return {n2, n1, n0};
	endfunction

	function automatic logic [17:0] pack_pixel(input int x, input int y, input colour_t c);
		return {pix_x_t'(x), pix_y_t'(y), c}; // coordinates wrap at their width
	endfunction

	task automatic reset_model();
		for (int i = 0; i < NUM_BIRDS; i++)
		begin
			bird_col[i] = i * BIRD_SPACING;
			bird_lfsr[i] = 3'(i + 1);
			bird_sx[i] = bird_col[i];
			bird_sy[i] = (i + 1) * 8 + 4;
			bird_wraps[i] = 0;
		end
		hunter_col = HUNTER_START_X;
		hunter_sx = HUNTER_START_X;
	endtask

	// applies one game step and expands the pass that follows
	task automatic advance_model();
		int n;
		n = 0;
		for (int i = 0; i < NUM_BIRDS; i++)
		begin
			if (bird_col[i] == SCREEN_W - 1)
			begin
				bird_col[i] = 0;
				bird_lfsr[i] = lfsr_advance(bird_lfsr[i]);
			end
			else
				bird_col[i]++;
		end
		if (move_right && hunter_col < SCREEN_W - HUNTER_W)
			hunter_col++;
		else if (move_left && hunter_col > 0)
			hunter_col--;
		for (int i = 0; i < NUM_BIRDS; i++)
		begin
			for (int k = 0; k < 13; k++)
				exp_pix[n + k] = pack_pixel(bird_sx[i] + BIRD_DX[k], bird_sy[i] + BIRD_DY[k],
					COLOUR_BG);
			bird_sx[i] = bird_col[i];
			bird_sy[i] = int'(bird_lfsr[i]) * 8 + 4;
			for (int k = 0; k < 13; k++)
				exp_pix[n + 13 + k] = pack_pixel(bird_sx[i] + BIRD_DX[k],
					bird_sy[i] + BIRD_DY[k], COLOUR_BIRD);
			n += 26;
		end
		for (int k = 0; k < 10; k++)
			exp_pix[n + k] = pack_pixel(hunter_sx + HUNTER_DX[k], HUNTER_ROW + HUNTER_DY[k],
				COLOUR_BG);
		hunter_sx = hunter_col;
		for (int k = 0; k < 10; k++)
			exp_pix[n + 10 + k] = pack_pixel(hunter_sx + HUNTER_DX[k],
				HUNTER_ROW + HUNTER_DY[k], COLOUR_HUNTER);
	endtask

	task automatic check_pixel(input int n);
		pix_x_t exp_x;
		pix_y_t exp_y;
		colour_t exp_c;
		{exp_x, exp_y, exp_c} = exp_pix[n];
		checks++;
		if (pixel_x !== exp_x)
		begin
			$display("[FAIL] t=%0t pixel_x expected %0d got %0d (pixel %0d)", $time, exp_x,
				pixel_x, n);
			errors++;
		end
		if (pixel_y !== exp_y)
		begin
			$display("[FAIL] t=%0t pixel_y expected %0d got %0d (pixel %0d)", $time, exp_y,
				pixel_y, n);
			errors++;
		end
		if (pixel_colour !== exp_c)
		begin
			$display("[FAIL] t=%0t pixel_colour expected %0d got %0d (pixel %0d)", $time,
				exp_c, pixel_colour, n);
			errors++;
		end
		if (n < NUM_BIRDS * 26 && n % 26 == 13 && pixel_x == 0)
			bird_wraps[n / 26]++; // head drawn at the left edge
		if (n == HUNTER_DRAW_FIRST)
			hunter_seen_x = int'(pixel_x) - 1; // head sits one column right
	endtask

	// waits for one step and collects its whole pass
	task automatic run_pass(input bit random_ready, input bit first_pass);
		int n;
		int waited;
		advance_model();
		n = 0;
		waited = 0;
		while (n < PASS_PIXELS && waited < 2 * STEP_CYCLES)
		begin
			@(posedge clock);
			#1;
			pixel_ready = random_ready ? ($urandom % 4 != 0) : 1'b1;
			@(negedge clock);
			waited++;
			if (pixel_valid && pixel_ready)
			begin
				if (first_pass && waited < STEP_CYCLES)
				begin
					$display("[FAIL] t=%0t pixel accepted before the first step", $time);
					errors++;
				end
				check_pixel(n);
				n++;
			end
		end
		if (n < PASS_PIXELS)
		begin
			$display("[FAIL] t=%0t pass stalled after %0d of %0d pixels", $time, n,
				PASS_PIXELS);
			errors++;
		end
		else
		begin
			@(negedge clock);
			if (pixel_valid)
			begin
				$display("[FAIL] t=%0t pixel stream still valid after the pass", $time);
				errors++;
			end
		end
	endtask

	task automatic set_buttons(input logic left, input logic right);
		@(posedge clock);
		#1;
		move_left = left;
		move_right = right;
	endtask

	task automatic first_pass_after_reset();
		run_pass(1'b0, 1'b1);
	endtask

	task automatic backpressure_passes();
		repeat (10) run_pass(1'b1, 1'b0);
	endtask

	task automatic hunter_clamp();
		set_buttons(1'b1, 1'b0);
		repeat (90) run_pass(1'b0, 1'b0);
		if (hunter_seen_x != 0)
		begin
			$display("[FAIL] t=%0t hunter column expected 0 got %0d", $time, hunter_seen_x);
			errors++;
		end
		set_buttons(1'b0, 1'b1);
		repeat (170) run_pass(1'b0, 1'b0);
		if (hunter_seen_x != SCREEN_W - HUNTER_W)
		begin
			$display("[FAIL] t=%0t hunter column expected %0d got %0d", $time,
				SCREEN_W - HUNTER_W, hunter_seen_x);
			errors++;
		end
		set_buttons(1'b0, 1'b0);
	endtask

	task automatic bird_wrap_rows();
		for (int i = 0; i < NUM_BIRDS; i++)
			bird_wraps[i] = 0;
		repeat (170) run_pass(1'b1, 1'b0);
		for (int i = 0; i < NUM_BIRDS; i++)
		begin
			if (bird_wraps[i] == 0)
			begin
				$display("[FAIL] t=%0t bird %0d never drawn at the left edge after a wrap",
					$time, i);
				errors++;
			end
		end
	endtask

	initial
	begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	initial
	begin
		cycle_count = 0;
		while (cycle_count < CYCLE_LIMIT)
		begin
			@(posedge clock);
			cycle_count++;
		end
		$display("run stopped at the cycle limit of %0d", CYCLE_LIMIT);
		$display("SIMULATION FAILED");
		$finish;
	end

	initial
	begin
		void'($urandom(32'hadb2a054));
		errors = 0;
		checks = 0;
		hunter_seen_x = -1;
		reset = 1'b1;
		move_left = 1'b0;
		move_right = 1'b0;
		pixel_ready = 1'b0;
		reset_model();
		#1 reset = 1'b0; // falling edge starts the async reset
		repeat (3) @(posedge clock);
		#1 reset = 1'b1;
		first_pass_after_reset();
		backpressure_passes();
		hunter_clamp();
		bird_wrap_rows();
		$display("checks %0d, errors %0d, assertion failures %0d", checks, errors,
			UUT.u_chk.fail_count);
		if (errors == 0 && UUT.u_chk.fail_count == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

// File: compile.f
duck_hunt_pkg.sv
sprite_if.sv
frame_timer.sv
bird_sprite.sv
hunter_sprite.sv
render_sequencer.sv
duck_hunt_top.sv
duck_hunt_chk.sv
tb_duck_hunt.sv

// File: run_sim.sh
#!/bin/sh
# builds the duck hunt testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_duck_hunt \
	-f compile.f -o tb_duck_hunt
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/tb_duck_hunt > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^SIMULATION PASSED$" "$LOG"; then
	exit 0
fi
echo "pass message not found in $LOG"
exit 1
